//--- bench/des_checker.sv
`timescale 1ns/10ps

module des_checker (
  input  logic                 clk,
  input  logic                 rst,
  input  des_bus_pkg::wb_req_t wb_req,
  input  des_bus_pkg::wb_rsp_t wb_rsp,
  output int                   check_count,
  output int                   error_count
);
  import des_bus_pkg::*;
  import des_tables_pkg::*;

  block_t   key_m;
  block_t   data_m;
  block_t   result_m;
  block_t   next_result;
  logic     decrypt_m;
  logic     busy_m;
  logic     done_m;
  logic     start_m;
  int       round_m;
  wb_word_t rd_exp;
  wb_adr_t  rd_adr;
  logic     rd_we;
  int       bus_checks = 0;
  int       bus_errors = 0;

  assign check_count = bus_checks;
  assign error_count = bus_errors;

  function automatic half_t feistel(input half_t r, input subkey_t k);
    subkey_t  x;
    half_t    s;
    sbox_in_t six;
    int       v;
    for (int j = 0; j < 48; j++) x[47 - j] = r[32 - E_TABLE[j]];
    x = x ^ k;
    for (int i = 0; i < 8; i++) begin
      six = x[47 - 6 * i -: 6];
      v = SBOX[i][six];
      s[31 - 4 * i -: 4] = v[3:0];
    end
    for (int j = 0; j < 32; j++) feistel[31 - j] = s[32 - P_TABLE[j]];
  endfunction

  function automatic block_t des_model(input block_t key, input block_t blk,
                                       input logic decrypt);
    subkey_t     ks [N_ROUNDS];
    logic [55:0] cd;
    cd_t         c;
    cd_t         d;
    block_t      perm;
    half_t       l;
    half_t       r;
    half_t       t;
    for (int j = 0; j < 56; j++) cd[55 - j] = key[64 - PC1_TABLE[j]];
    c = cd[55:28];
    d = cd[27:0];
    for (int i = 0; i < N_ROUNDS; i++) begin
      for (int n = 0; n < SHIFT_SCHED[i]; n++) begin
        c = {c[26:0], c[27]};
        d = {d[26:0], d[27]};
      end
      cd = {c, d};
      for (int j = 0; j < 48; j++) ks[i][47 - j] = cd[56 - PC2_TABLE[j]];
    end
    for (int j = 0; j < 64; j++) perm[63 - j] = blk[64 - IP_TABLE[j]];
    l = perm[63:32];
    r = perm[31:0];
    // decrypt reads the forward subkeys in reverse
    for (int i = 0; i < N_ROUNDS; i++) begin
      t = r;
      r = l ^ feistel(r, ks[decrypt ? N_ROUNDS - 1 - i : i]);
      l = t;
    end
    perm = {r, l};
    for (int j = 0; j < 64; j++) des_model[63 - j] = perm[64 - FP_TABLE[j]];
  endfunction

  function automatic wb_word_t read_value(input wb_adr_t adr);
    read_value = '0;
    case (adr)
      ADR_KEY_HI:  read_value = key_m[63:32];
      ADR_KEY_LO:  read_value = key_m[31:0];
      ADR_DATA_HI: read_value = data_m[63:32];
      ADR_DATA_LO: read_value = data_m[31:0];
      ADR_CTRL:    read_value[CTRL_DECRYPT] = decrypt_m;
      ADR_STATUS: begin
        read_value[STAT_BUSY] = busy_m;
        read_value[STAT_DONE] = done_m;
      end
      ADR_RES_HI:  read_value = result_m[63:32];
      default:     read_value = result_m[31:0];
    endcase
  endfunction

  // sampled values are those of the cycle before the edge
  always @(posedge clk) begin : monitor
    logic access;
    logic accept;
    access = wb_req.cyc && wb_req.stb && !wb_rsp.ack;
    accept = start_m && !busy_m;
    if (rst) begin
      key_m = '0;
      data_m = '0;
      result_m = '0;
      decrypt_m = 1'b0;
      busy_m = 1'b0;
      done_m = 1'b0;
      start_m = 1'b0;
      round_m = 0;
      rd_we = 1'b1;
    end else begin
      if (wb_rsp.ack && !rd_we) begin
        bus_checks++;
        if (wb_rsp.dat !== rd_exp) begin
          $display("Error: wb_rsp.dat at address %h expected %h got %h",
                   rd_adr, rd_exp, wb_rsp.dat);
          bus_errors++;
        end
      end
      if (access) begin
        rd_exp = read_value(wb_req.adr);
        rd_adr = wb_req.adr;
        rd_we = wb_req.we;
      end
      if (busy_m) begin
        if (round_m == N_ROUNDS) begin
          busy_m = 1'b0;
          done_m = 1'b1;
          result_m = next_result;
          round_m = 0;
        end else begin
          round_m++;
        end
      end
      if (accept) begin
        next_result = des_model(key_m, data_m, decrypt_m);
        busy_m = 1'b1;
        done_m = 1'b0;
        round_m = 1;
      end
      start_m = 1'b0;
      if (access && wb_req.we) begin
        case (wb_req.adr)
          ADR_KEY_HI:  key_m[63:32] = wb_req.dat;
          ADR_KEY_LO:  key_m[31:0] = wb_req.dat;
          ADR_DATA_HI: data_m[63:32] = wb_req.dat;
          ADR_DATA_LO: data_m[31:0] = wb_req.dat;
          ADR_CTRL: begin
            decrypt_m = wb_req.dat[CTRL_DECRYPT];
            start_m = wb_req.dat[CTRL_START];
          end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- bench/des_sva.sv
`timescale 1ns/10ps

module des_sva (
  input logic                 clk,
  input logic                 rst,
  input des_bus_pkg::wb_req_t wb_req,
  input des_bus_pkg::wb_rsp_t wb_rsp,
  input logic                 busy,
  input logic                 done
);

  // ack answers a strobe seen on the previous edge
  ack_after_strobe: assert property (@(posedge clk) disable iff (rst)
    wb_rsp.ack |-> $past(wb_req.cyc && wb_req.stb))
    else $error("ack without a strobe on the previous edge");

  ack_one_cycle: assert property (@(posedge clk) disable iff (rst)
    wb_rsp.ack |=> !wb_rsp.ack)
    else $error("ack held for two cycles");

  busy_done_exclusive: assert property (@(posedge clk) disable iff (rst)
    !(busy && done))
    else $error("busy and done high together");

endmodule

bind des_wb_regs des_sva wb_regs_sva_inst (
  .clk    (clk),
  .rst    (rst),
  .wb_req (wb_req),
  .wb_rsp (wb_rsp),
  .busy   (busy),
  .done   (done)
);

//--- bench/tb_des.sv
`timescale 1ns/10ps

module tb_des;
  import des_bus_pkg::*;
  import des_tables_pkg::*;

  localparam block_t KAT_KEY = 64'h1334_5779_9bbc_dff1;
  localparam block_t KAT_PT  = 64'h0123_4567_89ab_cdef;
  localparam block_t KAT_CT  = 64'h85e8_1354_0f0a_b405;

  logic        clk;
  logic        rst;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  int          cycles = 0;
  int          timeouts;
  int          tb_errors;
  int          checks;
  int          chk_errors;
  int unsigned seed;
  block_t      key;
  block_t      blk;
  block_t      res;
  block_t      back;
  wb_word_t    word;

  des_top des_top_inst (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp)
  );

  des_checker checker_inst (
    .clk         (clk),
    .rst         (rst),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .check_count (checks),
    .error_count (chk_errors)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk) cycles <= cycles + 1;

  // one classic cycle, released in the ack cycle
  task automatic wb_access(input logic we, input wb_adr_t adr, input wb_word_t wdat,
                           output wb_word_t rdat);
    int   waited;
    logic acked;
    waited = 0;
    acked = 1'b0;
    rdat = '0;
    @(posedge clk);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    while (!acked && waited < 20) begin
      @(posedge clk);
      if (wb_rsp.ack) begin
        acked = 1'b1;
        rdat = wb_rsp.dat;
      end else begin
        waited++;
      end
    end
    wb_req <= '0;
    if (!acked) begin
      $display("timeout: no ack from the DUT at address %0d", adr);
      timeouts++;
    end
  endtask

  task automatic wb_write(input wb_adr_t adr, input wb_word_t dat);
    wb_word_t unused;
    wb_access(1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input wb_adr_t adr, output wb_word_t dat);
    wb_access(1'b0, adr, '0, dat);
  endtask

  function automatic wb_word_t ctrl_word(input logic decrypt);
    ctrl_word = '0;
    ctrl_word[CTRL_START] = 1'b1;
    ctrl_word[CTRL_DECRYPT] = decrypt;
  endfunction

  task automatic load_job(input block_t k, input block_t b);
    wb_write(ADR_KEY_HI, k[63:32]);
    wb_write(ADR_KEY_LO, k[31:0]);
    wb_write(ADR_DATA_HI, b[63:32]);
    wb_write(ADR_DATA_LO, b[31:0]);
  endtask

  task automatic wait_done();
    wb_word_t st;
    int       t0;
    st = '0;
    t0 = cycles;
    while (!st[STAT_DONE] && (cycles - t0) < 100) wb_read(ADR_STATUS, st);
    if (!st[STAT_DONE]) begin
      $display("timeout: engine never reported done");
      timeouts++;
    end
  endtask

  task automatic run_job(input block_t k, input block_t b, input logic decrypt,
                         output block_t result);
    wb_word_t hi;
    wb_word_t lo;
    load_job(k, b);
    wb_write(ADR_CTRL, ctrl_word(decrypt));
    wait_done();
    wb_read(ADR_RES_HI, hi);
    wb_read(ADR_RES_LO, lo);
    result = {hi, lo};
  endtask

  task automatic check_block(input string name, input block_t expected, input block_t actual);
    if (actual !== expected) begin
      $display("Error: %s expected %h got %h", name, expected, actual);
      tb_errors++;
    end
  endtask

  initial begin
    seed = $urandom(32'h41bc_5eb2);
    rst <= 1'b1;
    wb_req <= '0;
    timeouts = 0;
    tb_errors = 0;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    // reset values, then readback of key and data
    wb_read(ADR_STATUS, word);
    wb_read(ADR_RES_HI, word);
    wb_read(ADR_RES_LO, word);
    key = {$urandom, $urandom};
    blk = {$urandom, $urandom};
    load_job(key, blk);
    for (int a = 0; a < 4; a++) wb_read(wb_adr_t'(a), word);
    run_job(KAT_KEY, KAT_PT, 1'b0, res);
    check_block("result (known answer encrypt)", KAT_CT, res);
    run_job(KAT_KEY, res, 1'b1, back);
    check_block("result (known answer decrypt)", KAT_PT, back);
    for (int i = 0; i < 40; i++) begin
      key = {$urandom, $urandom};
      blk = {$urandom, $urandom};
      run_job(key, blk, 1'b0, res);
    end
    for (int i = 0; i < 40; i++) begin
      key = {$urandom, $urandom};
      blk = {$urandom, $urandom};
      run_job(key, blk, 1'b1, res);
      run_job(key, res, 1'b0, back);
      check_block("result (decrypt round trip)", blk, back);
    end
    // second start with new data lands while busy
    key = {$urandom, $urandom};
    blk = {$urandom, $urandom};
    load_job(key, blk);
    wb_write(ADR_CTRL, ctrl_word(1'b0));
    wb_write(ADR_DATA_HI, $urandom);
    wb_write(ADR_DATA_LO, $urandom);
    wb_write(ADR_CTRL, ctrl_word(1'b0));
    wait_done();
    wb_read(ADR_RES_HI, word);
    wb_read(ADR_RES_LO, word);
    wb_read(ADR_STATUS, word);
    repeat (2) @(posedge clk);
    $display("bus checks %0d, checker errors %0d, testbench errors %0d, timeouts %0d",
             checks, chk_errors, tb_errors, timeouts);
    if (chk_errors + tb_errors + timeouts == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

//--- hdl/des_bus_pkg.sv
package des_bus_pkg;

  typedef logic [2:0]  wb_adr_t;
  typedef logic [31:0] wb_word_t;

  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_adr_t  adr;
    wb_word_t dat;
  } wb_req_t;

  typedef struct packed {
    logic     ack;
    wb_word_t dat;
  } wb_rsp_t;

  // word addresses
  localparam wb_adr_t ADR_KEY_HI  = 3'd0;
  localparam wb_adr_t ADR_KEY_LO  = 3'd1;
  localparam wb_adr_t ADR_DATA_HI = 3'd2;
  localparam wb_adr_t ADR_DATA_LO = 3'd3;
  localparam wb_adr_t ADR_CTRL    = 3'd4;
  localparam wb_adr_t ADR_STATUS  = 3'd5;
  localparam wb_adr_t ADR_RES_HI  = 3'd6;
  localparam wb_adr_t ADR_RES_LO  = 3'd7;

  localparam int CTRL_START   = 0;
  localparam int CTRL_DECRYPT = 1;

  localparam int STAT_BUSY = 0;
  localparam int STAT_DONE = 1;

endpackage

//--- hdl/des_engine.sv
`timescale 1ns/10ps

module des_engine (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     start,
  input  des_tables_pkg::des_job_t job,
  output des_tables_pkg::block_t   result,
  output logic                     busy,
  output logic                     done
);
  import des_tables_pkg::*;

  typedef enum logic {
    IDLE,
    RUN
  } engine_state_t;

  engine_state_t state;
  round_t        round_q;
  half_t         l_q;
  half_t         r_q;
  half_t         f_val;
  half_t         r_next;
  subkey_t       subkey;
  block_t        ip_out;
  block_t        fp_out;
  block_t        preout;
  logic          accept;

  assign busy   = (state == RUN);
  assign accept = start && (state == IDLE);

  des_key_sched key_sched_inst (
    .clk     (clk),
    .rst     (rst),
    .load    (accept),
    .key     (job.key),
    .decrypt (job.decrypt),
    .round   (round_q),
    .subkey  (subkey)
  );

  des_round_f round_f_inst (
    .r      (r_q),
    .subkey (subkey),
    .f_out  (f_val)
  );

  assign r_next = l_q ^ f_val;
  // halves swapped before the final permutation
  assign preout = {r_next, r_q};

  always_comb begin
    for (int j = 0; j < 64; j++) begin
      ip_out[63 - j] = job.block[64 - IP_TABLE[j]];
      fp_out[63 - j] = preout[64 - FP_TABLE[j]];
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      l_q <= ip_out[63:32];
      r_q <= ip_out[31:0];
    end else if (state == RUN) begin
      l_q <= r_q;
      r_q <= r_next;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= IDLE;
      round_q <= '0;
      done    <= 1'b0;
      result  <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            state   <= RUN;
            round_q <= round_t'(1);
            done    <= 1'b0;
          end
        end
        RUN: begin
          if (round_q == round_t'(N_ROUNDS)) begin
            state   <= IDLE;
            round_q <= '0;
            done    <= 1'b1;
            result  <= fp_out;
          end else begin
            round_q <= round_q + round_t'(1);
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- hdl/des_key_sched.sv
`timescale 1ns/10ps

module des_key_sched (
  input  logic                    clk,
  input  logic                    rst,
  input  logic                    load,
  input  des_tables_pkg::block_t  key,
  input  logic                    decrypt,
  input  des_tables_pkg::round_t  round,
  output des_tables_pkg::subkey_t subkey
);
  import des_tables_pkg::*;

  cd_t        c_q;
  cd_t        d_q;
  cd_t        c_rot;
  cd_t        d_rot;
  logic       dec_q;
  int         shift;
  logic [55:0] pc1_out;
  logic [55:0] cd_rot;

  function automatic cd_t rotate(input cd_t v, input int n, input logic right);
    if (right) return (v >> n) | (v << ($bits(cd_t) - n));
    return (v << n) | (v >> ($bits(cd_t) - n));
  endfunction

  always_comb begin
    for (int j = 0; j < 56; j++) pc1_out[55 - j] = key[64 - PC1_TABLE[j]];
  end

  // round 0 means idle, nothing moves
  // decrypt walks back through the encrypt schedule, first round unrotated
  always_comb begin
    shift = 0;
    if (round != '0) begin
      if (!dec_q) shift = SHIFT_SCHED[int'(round) - 1];
      else if (round > 5'd1) shift = SHIFT_SCHED[17 - int'(round)];
    end
    c_rot  = rotate(c_q, shift, dec_q);
    d_rot  = rotate(d_q, shift, dec_q);
    cd_rot = {c_rot, d_rot};
    for (int j = 0; j < 48; j++) subkey[47 - j] = cd_rot[56 - PC2_TABLE[j]];
  end

  always_ff @(posedge clk) begin
    if (load) begin
      c_q <= pc1_out[55:28];
      d_q <= pc1_out[27:0];
    end else begin
      c_q <= c_rot;
      d_q <= d_rot;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) dec_q <= 1'b0;
    else if (load) dec_q <= decrypt;
  end

endmodule

//--- hdl/des_round_f.sv
`timescale 1ns/10ps

module des_round_f (
  input  des_tables_pkg::half_t   r,
  input  des_tables_pkg::subkey_t subkey,
  output des_tables_pkg::half_t   f_out
);
  import des_tables_pkg::*;

  subkey_t  expanded;
  subkey_t  mixed;
  half_t    s_out;
  sbox_in_t idx [8];

  // expansion, 48 bits out of 32
  always_comb begin
    for (int j = 0; j < 48; j++) expanded[47 - j] = r[32 - E_TABLE[j]];
  end

  assign mixed = expanded ^ subkey;

  // s1 takes the top six bits
  always_comb begin
    for (int i = 0; i < 8; i++) begin
      idx[i] = mixed[47 - 6 * i -: 6];
      s_out[31 - 4 * i -: 4] = nibble_t'(SBOX[i][idx[i]]);
    end
  end

  always_comb begin
    for (int j = 0; j < 32; j++) f_out[31 - j] = s_out[32 - P_TABLE[j]];
  end

endmodule

//--- hdl/des_tables_pkg.sv
package des_tables_pkg;

  typedef logic [63:0] block_t;
  typedef logic [31:0] half_t;
  typedef logic [27:0] cd_t;
  typedef logic [47:0] subkey_t;
  typedef logic [5:0]  sbox_in_t;
  typedef logic [3:0]  nibble_t;
  typedef logic [4:0]  round_t;

  typedef struct packed {
    block_t key;
    block_t block;
    logic   decrypt;
  } des_job_t;

  localparam int N_ROUNDS = 16;

  // source bit positions, 1 is the msb of the input word
  localparam int IP_TABLE [64] = '{
    58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
    62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
    57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
    61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
  };

  localparam int FP_TABLE [64] = '{
    40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
    38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
    36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
    34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25
  };

  localparam int E_TABLE [48] = '{
    32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9,
    8, 9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
    16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
    24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
  };

  localparam int P_TABLE [32] = '{
    16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
    2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
  };

  // first 28 entries feed C, the rest feed D
  localparam int PC1_TABLE [56] = '{
    57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
    10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
    63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
    14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
  };

  localparam int PC2_TABLE [48] = '{
    14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10,
    23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
    41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
    44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
  };

  // indexed directly by the 6-bit input, not by row and column
  localparam int SBOX [8][64] = '{
    '{14, 0, 4, 15, 13, 7, 1, 4, 2, 14, 15, 2, 11, 13, 8, 1,
      3, 10, 10, 6, 6, 12, 12, 11, 5, 9, 9, 5, 0, 3, 7, 8,
      4, 15, 1, 12, 14, 8, 8, 2, 13, 4, 6, 9, 2, 1, 11, 7,
      15, 5, 12, 11, 9, 3, 7, 14, 3, 10, 10, 0, 5, 6, 0, 13},
    '{15, 3, 1, 13, 8, 4, 14, 7, 6, 15, 11, 2, 3, 8, 4, 14,
      9, 12, 7, 0, 2, 1, 13, 10, 12, 6, 0, 9, 5, 11, 10, 5,
      0, 13, 14, 8, 7, 10, 11, 1, 10, 3, 4, 15, 13, 4, 1, 2,
      5, 11, 8, 6, 12, 7, 6, 12, 9, 0, 3, 5, 2, 14, 15, 9},
    '{10, 13, 0, 7, 9, 0, 14, 9, 6, 3, 3, 4, 15, 6, 5, 10,
      1, 2, 13, 8, 12, 5, 7, 14, 11, 12, 4, 11, 2, 15, 8, 1,
      13, 1, 6, 10, 4, 13, 9, 0, 8, 6, 15, 9, 3, 8, 0, 7,
      11, 4, 1, 15, 2, 14, 12, 3, 5, 11, 10, 5, 14, 2, 7, 12},
    '{7, 13, 13, 8, 14, 11, 3, 5, 0, 6, 6, 15, 9, 0, 10, 3,
      1, 4, 2, 7, 8, 2, 5, 12, 11, 1, 12, 10, 4, 14, 15, 9,
      10, 3, 6, 15, 9, 0, 0, 6, 12, 10, 11, 1, 7, 13, 13, 8,
      15, 9, 1, 4, 3, 5, 14, 11, 5, 12, 2, 7, 8, 2, 4, 14},
    '{2, 14, 12, 11, 4, 2, 1, 12, 7, 4, 10, 7, 11, 13, 6, 1,
      8, 5, 5, 0, 3, 15, 15, 10, 13, 3, 0, 9, 14, 8, 9, 6,
      4, 11, 2, 8, 1, 12, 11, 7, 10, 1, 13, 14, 7, 2, 8, 13,
      15, 6, 9, 15, 12, 0, 5, 9, 6, 10, 3, 4, 0, 5, 14, 3},
    '{12, 10, 1, 15, 10, 4, 15, 2, 9, 7, 2, 12, 6, 9, 8, 5,
      0, 6, 13, 1, 3, 13, 4, 14, 14, 0, 7, 11, 5, 3, 11, 8,
      9, 4, 14, 3, 15, 2, 5, 12, 2, 9, 8, 5, 12, 15, 3, 10,
      7, 11, 0, 14, 4, 1, 10, 7, 1, 6, 13, 0, 11, 8, 6, 13},
    '{4, 13, 11, 0, 2, 11, 14, 7, 15, 4, 0, 9, 8, 1, 13, 10,
      3, 14, 12, 3, 9, 5, 7, 12, 5, 2, 10, 15, 6, 8, 1, 6,
      1, 6, 4, 11, 11, 13, 13, 8, 12, 1, 3, 4, 7, 10, 14, 7,
      10, 9, 15, 5, 6, 0, 8, 15, 0, 14, 5, 2, 9, 3, 2, 12},
    '{13, 1, 2, 15, 8, 13, 4, 8, 6, 10, 15, 3, 11, 7, 1, 4,
      10, 12, 9, 5, 3, 6, 14, 11, 5, 0, 0, 14, 12, 9, 7, 2,
      7, 2, 11, 1, 4, 14, 1, 7, 9, 4, 12, 10, 14, 8, 2, 13,
      0, 15, 6, 12, 10, 9, 13, 0, 15, 3, 3, 5, 5, 6, 8, 11}
  };

  // left rotation per encrypt round
  localparam int SHIFT_SCHED [16] = '{
    1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1
  };

endpackage

//--- hdl/des_top.sv
`timescale 1ns/10ps

module des_top (
  input  logic                 clk,
  input  logic                 rst,
  input  des_bus_pkg::wb_req_t wb_req,
  output des_bus_pkg::wb_rsp_t wb_rsp
);
  import des_tables_pkg::*;

  des_job_t job;
  block_t   result;
  logic     start;
  logic     busy;
  logic     done;

  des_wb_regs wb_regs_inst (
    .clk    (clk),
    .rst    (rst),
    .wb_req (wb_req),
    .wb_rsp (wb_rsp),
    .start  (start),
    .job    (job),
    .result (result),
    .busy   (busy),
    .done   (done)
  );

  // engine ignores start while busy
  des_engine engine_inst (
    .clk    (clk),
    .rst    (rst),
    .start  (start),
    .job    (job),
    .result (result),
    .busy   (busy),
    .done   (done)
  );

endmodule

//--- hdl/des_wb_regs.sv
`timescale 1ns/10ps

module des_wb_regs (
  input  logic                     clk,
  input  logic                     rst,
  input  des_bus_pkg::wb_req_t     wb_req,
  output des_bus_pkg::wb_rsp_t     wb_rsp,
  output logic                     start,
  output des_tables_pkg::des_job_t job,
  input  des_tables_pkg::block_t   result,
  input  logic                     busy,
  input  logic                     done
);
  import des_bus_pkg::*;
  import des_tables_pkg::*;

  wb_word_t key_hi;
  wb_word_t key_lo;
  wb_word_t data_hi;
  wb_word_t data_lo;
  logic     decrypt_q;
  logic     ack_q;
  wb_word_t dat_q;
  wb_word_t rd_word;
  logic     access;
  logic     wr;

  // a held stb after ack is not a new access
  assign access = wb_req.cyc && wb_req.stb && !ack_q;
  assign wr     = access && wb_req.we;

  always_comb begin
    rd_word = '0;
    case (wb_req.adr)
      ADR_KEY_HI:  rd_word = key_hi;
      ADR_KEY_LO:  rd_word = key_lo;
      ADR_DATA_HI: rd_word = data_hi;
      ADR_DATA_LO: rd_word = data_lo;
      ADR_CTRL:    rd_word[CTRL_DECRYPT] = decrypt_q;
      ADR_STATUS: begin
        rd_word[STAT_BUSY] = busy;
        rd_word[STAT_DONE] = done;
      end
      ADR_RES_HI:  rd_word = result[63:32];
      ADR_RES_LO:  rd_word = result[31:0];
      default:     rd_word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      key_hi    <= '0;
      key_lo    <= '0;
      data_hi   <= '0;
      data_lo   <= '0;
      decrypt_q <= 1'b0;
      ack_q     <= 1'b0;
      dat_q     <= '0;
      start     <= 1'b0;
    end else begin
      ack_q <= access;
      start <= 1'b0;
      if (access) dat_q <= rd_word;
      if (wr) begin
        case (wb_req.adr)
          ADR_KEY_HI:  key_hi  <= wb_req.dat;
          ADR_KEY_LO:  key_lo  <= wb_req.dat;
          ADR_DATA_HI: data_hi <= wb_req.dat;
          ADR_DATA_LO: data_lo <= wb_req.dat;
          ADR_CTRL: begin
            decrypt_q <= wb_req.dat[CTRL_DECRYPT];
            // pulse lines up with ack
            start     <= wb_req.dat[CTRL_START];
          end
          default: ;
        endcase
      end
    end
  end

  assign job = '{key: {key_hi, key_lo}, block: {data_hi, data_lo}, decrypt: decrypt_q};

  assign wb_rsp = '{ack: ack_q, dat: dat_q};

endmodule

//--- project.f
hdl/des_tables_pkg.sv
hdl/des_bus_pkg.sv
hdl/des_key_sched.sv
hdl/des_round_f.sv
hdl/des_engine.sv
hdl/des_wb_regs.sv
hdl/des_top.sv
bench/des_sva.sv
bench/des_checker.sv
bench/tb_des.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the DES core testbench with Verilator
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/10ps \
  --top-module tb_des -f project.f -o tb_des_sim
./obj_dir/tb_des_sim | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
  exit 1
fi
